/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_vex
FILELIST  := vex.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := Test failed
SOURCES   := $(wildcard hw/*.sv) $(wildcard sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	if [ $$status -ne 0 ]; then exit $$status; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hw/operand_fetch.sv */
`timescale 1ns/1ps

module operand_fetch (
    input  logic                          CLK,
    input  logic                          arst_n,
    input  logic                          in_valid,
    output logic                          in_ready,
    input  vex_pkg::valu_op_t             in_op,
    input  logic                          in_red,
    input  vex_pkg::vreg_idx_t            in_vd,
    input  vex_pkg::vreg_idx_t            in_vs1,
    input  vex_pkg::vreg_idx_t            in_vs2,
    input  vex_pkg::vsrc1_sel_t           in_src1_sel,
    input  vex_pkg::word_t                in_rs1,
    input  logic [vex_pkg::imm_w-1:0]     in_imm,
    input  logic                          in_mask_en,
    input  logic                          in_regwen,
    input  vex_pkg::word_t                vl,
    input  vex_pkg::lane_words_t          bank_a,
    input  vex_pkg::lane_words_t          bank_b,
    input  vex_pkg::word_t                lane0_v0,
    input  vex_pkg::vreg_idx_t            ex_vd,
    input  vex_pkg::vreg_idx_t            wb_vd,
    input  logic                          ex_busy,
    input  logic                          wb_busy,
    output logic                          ex_valid,
    input  logic                          ex_ready,
    output vex_pkg::ex_payload_t          ex_payload
);

logic                 use_vs1;
logic                 hit_ex;
logic                 hit_wb;
logic                 raw_stall;
vex_pkg::word_t       imm_sext;
vex_pkg::lane_words_t opnd_b;
vex_pkg::lane_mask_t  lane_mask;

// vs1 is read for vector sources and always as the reduction seed
assign use_vs1 = in_red || (in_src1_sel == vex_pkg::src1_vec);

// RAW check against both stages that will still write a register
assign hit_ex = ex_busy && ((ex_vd == in_vs2) ||
                            (use_vs1 && (ex_vd == in_vs1)) ||
                            (in_mask_en && (ex_vd == '0)));
assign hit_wb = wb_busy && ((wb_vd == in_vs2) ||
                            (use_vs1 && (wb_vd == in_vs1)) ||
                            (in_mask_en && (wb_vd == '0)));
assign raw_stall = hit_ex || hit_wb;

assign in_ready = ex_ready && !raw_stall;
assign ex_valid = in_valid && !raw_stall;

assign imm_sext = {{(vex_pkg::word_w - vex_pkg::imm_w){in_imm[vex_pkg::imm_w-1]}}, in_imm};

always_comb begin
    case (in_src1_sel)
        vex_pkg::src1_scalar: opnd_b = {vex_pkg::num_lanes{in_rs1}};
        vex_pkg::src1_imm:    opnd_b = {vex_pkg::num_lanes{imm_sext}};
        default:              opnd_b = bank_b;
    endcase
end

// lane k lives when below vl and, if masked, v0 bit k is set
always_comb begin
    for (int k = 0; k < vex_pkg::num_lanes; k++) begin
        lane_mask[k] = (vex_pkg::word_t'(k) < vl) && (!in_mask_en || lane0_v0[k]);
    end
end

always_comb begin
    ex_payload.op        = in_op;
    ex_payload.red       = in_red;
    ex_payload.vd        = in_vd;
    ex_payload.regwen    = in_regwen;
    ex_payload.lane_mask = lane_mask;
    ex_payload.a         = bank_a;
    ex_payload.b         = opnd_b;
    ex_payload.seed      = bank_b;
end

// a uop that just entered execute blocks any follower reading its vd
a_raw_follow: assert property (@(posedge CLK) disable iff (!arst_n)
    (ex_valid && ex_ready && in_regwen) |=>
        !(ex_valid && ((in_vs2 == $past(in_vd)) ||
                       (use_vs1 && (in_vs1 == $past(in_vd))) ||
                       (in_mask_en && ($past(in_vd) == '0)))));

// sub has no reduction form
a_no_sub_red: assert property (@(posedge CLK) disable iff (!arst_n)
    (in_valid && in_red) |-> (in_op != vex_pkg::valu_sub));

endmodule

/* hw/reduction_unit.sv */
`timescale 1ns/1ps

module reduction_unit (
    input  vex_pkg::valu_op_t    op,
    input  vex_pkg::lane_words_t elems,
    input  vex_pkg::lane_mask_t  lane_mask,
    input  vex_pkg::word_t       seed,
    output vex_pkg::word_t       res
);

vex_pkg::lane_words_t padded;
vex_pkg::word_t       pair_lo;
vex_pkg::word_t       pair_hi;
vex_pkg::word_t       lanes_res;

// value that leaves the other operand unchanged
function automatic vex_pkg::word_t identity(vex_pkg::valu_op_t f);
    case (f)
        vex_pkg::valu_and,
        vex_pkg::valu_minu: identity = '1;
        vex_pkg::valu_min:  identity = vex_pkg::word_smax;
        vex_pkg::valu_max:  identity = vex_pkg::word_smin;
        default:            identity = '0;
    endcase
endfunction

function automatic vex_pkg::word_t combine(vex_pkg::valu_op_t f,
                                           vex_pkg::word_t x, vex_pkg::word_t y);
    case (f)
        vex_pkg::valu_and:  combine = x & y;
        vex_pkg::valu_or:   combine = x | y;
        vex_pkg::valu_xor:  combine = x ^ y;
        vex_pkg::valu_min:  combine = ($signed(x) < $signed(y)) ? x : y;
        vex_pkg::valu_max:  combine = ($signed(x) < $signed(y)) ? y : x;
        vex_pkg::valu_minu: combine = (x < y) ? x : y;
        vex_pkg::valu_maxu: combine = (x < y) ? y : x;
        // add and the never-reduced sub
        default:            combine = x + y;
    endcase
endfunction

always_comb begin
    for (int k = 0; k < vex_pkg::num_lanes; k++) begin
        padded[k] = lane_mask[k] ? elems[k] : identity(op);
    end
end

// two-level tree over the lanes with the seed folded in last
assign pair_lo   = combine(op, padded[0], padded[1]);
assign pair_hi   = combine(op, padded[2], padded[3]);
assign lanes_res = combine(op, pair_lo, pair_hi);
assign res       = combine(op, seed, lanes_res);

endmodule

/* hw/result_select.sv */
`timescale 1ns/1ps

module result_select (
    input  vex_pkg::ex_payload_t ex_payload,
    input  vex_pkg::lane_words_t lane_res,
    input  vex_pkg::word_t       red_res,
    output vex_pkg::wb_payload_t wb_payload
);

// reductions land in element 0 only
localparam vex_pkg::lane_mask_t red_lane_mask = vex_pkg::lane_mask_t'(1);

always_comb begin
    wb_payload.vd     = ex_payload.vd;
    wb_payload.regwen = ex_payload.regwen;

    if (ex_payload.red) begin
        // lane 0 is written even if masked off itself
        wb_payload.lane_mask = red_lane_mask;
        wb_payload.result    = '0;
        wb_payload.result[0] = red_res;
    end else begin
        wb_payload.lane_mask = ex_payload.lane_mask;
        wb_payload.result    = lane_res;
    end
end

endmodule

/* hw/stage_reg.sv */
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     CLK,
    input  logic     arst_n,
    input  logic     up_valid,
    output logic     up_ready,
    input  payload_t up_payload,
    output logic     down_valid,
    input  logic     down_ready,
    output payload_t down_payload
);

logic     full;
payload_t data_q;

// accepts when empty or when the held entry leaves this cycle
assign up_ready     = !full || down_ready;
assign down_valid   = full;
assign down_payload = data_q;

always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
        full <= 1'b0;
    end else if (up_ready) begin
        full <= up_valid;
    end
end

always_ff @(posedge CLK) begin
    if (up_valid && up_ready) begin
        data_q <= up_payload;
    end
end

// held entry must not change under back-pressure
a_hold_stable: assert property (@(posedge CLK) disable iff (!arst_n)
    (down_valid && !down_ready) |=> (down_valid && $stable(down_payload)));

endmodule

/* hw/vex_pkg.sv */
package vex_pkg;

    // machine shape
    localparam int num_lanes  = 4;
    localparam int num_vregs  = 32;
    localparam int word_w     = 32;
    localparam int word_bytes = word_w / 8;
    localparam int vreg_idx_w = $clog2(num_vregs);
    localparam int imm_w      = 5;

    typedef logic [word_w-1:0]     word_t;
    typedef logic [vreg_idx_w-1:0] vreg_idx_t;
    typedef word_t [num_lanes-1:0] lane_words_t;
    typedef logic [num_lanes-1:0]  lane_mask_t;

    // signed extremes used as reduction identities
    localparam word_t word_smax = {1'b0, {(word_w-1){1'b1}}};
    localparam word_t word_smin = {1'b1, {(word_w-1){1'b0}}};

    typedef enum logic [3:0] {
        valu_add  = 4'd0,
        valu_sub  = 4'd1,
        valu_and  = 4'd2,
        valu_or   = 4'd3,
        valu_xor  = 4'd4,
        valu_min  = 4'd5,
        valu_max  = 4'd6,
        valu_minu = 4'd7,
        valu_maxu = 4'd8
    } valu_op_t;

    // where operand b comes from
    typedef enum logic [1:0] {
        src1_vec    = 2'd0,
        src1_scalar = 2'd1,
        src1_imm    = 2'd2
    } vsrc1_sel_t;

    // operand fetch to execute
    typedef struct packed {
        valu_op_t    op;
        logic        red;
        vreg_idx_t   vd;
        logic        regwen;
        lane_mask_t  lane_mask;
        lane_words_t a;
        lane_words_t b;
        lane_words_t seed;
    } ex_payload_t;

    // result select to writeback port
    // lane_mask marks the lanes that get written
    typedef struct packed {
        vreg_idx_t   vd;
        logic        regwen;
        lane_mask_t  lane_mask;
        lane_words_t result;
    } wb_payload_t;

endpackage

/* hw/vex_top.sv */
`timescale 1ns/1ps

module vex_top (
    input  logic                          CLK,
    input  logic                          arst_n,
    input  logic                          in_valid,
    output logic                          in_ready,
    input  vex_pkg::valu_op_t             in_op,
    input  logic                          in_red,
    input  vex_pkg::vreg_idx_t            in_vd,
    input  vex_pkg::vreg_idx_t            in_vs1,
    input  vex_pkg::vreg_idx_t            in_vs2,
    input  vex_pkg::vsrc1_sel_t           in_src1_sel,
    input  vex_pkg::word_t                in_rs1,
    input  logic [vex_pkg::imm_w-1:0]     in_imm,
    input  logic                          in_mask_en,
    input  logic                          in_regwen,
    input  vex_pkg::word_t                vl,
    output logic                          out_valid,
    input  logic                          out_ready,
    output vex_pkg::vreg_idx_t            out_vd,
    output logic                          out_regwen,
    output vex_pkg::lane_mask_t           out_lane_mask,
    output vex_pkg::lane_words_t          out_data
);

vex_pkg::lane_words_t bank_a;
vex_pkg::lane_words_t bank_b;
vex_pkg::lane_words_t v0_words;
logic                 ex_valid;
logic                 ex_ready;
vex_pkg::ex_payload_t ex_payload;
logic                 ex_q_valid;
logic                 ex_q_ready;
vex_pkg::ex_payload_t ex_q_payload;
vex_pkg::lane_words_t lane_res;
vex_pkg::word_t       red_res;
vex_pkg::wb_payload_t wb_payload;
vex_pkg::wb_payload_t wb_q_payload;
logic                 wb_fire;

// banks are written on the output handshake
assign wb_fire = out_valid && out_ready && out_regwen;

genvar k;
generate
    for (k = 0; k < vex_pkg::num_lanes; k++) begin : g_lane
        vreg_bank u_bank (
            .CLK        (CLK),
            .arst_n     (arst_n),
            .rd_idx_a   (in_vs2),
            .rd_idx_b   (in_vs1),
            .wr_idx     (wb_q_payload.vd),
            .wr_byte_en ({vex_pkg::word_bytes{wb_fire && wb_q_payload.lane_mask[k]}}),
            .wr_data    (wb_q_payload.result[k]),
            .rd_a       (bank_a[k]),
            .rd_b       (bank_b[k]),
            .rd_v0      (v0_words[k])
        );

        vlane_alu u_alu (
            .op  (ex_q_payload.op),
            .a   (ex_q_payload.a[k]),
            .b   (ex_q_payload.b[k]),
            .res (lane_res[k])
        );
    end
endgenerate

operand_fetch u_fetch (
    .CLK         (CLK),
    .arst_n      (arst_n),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_op       (in_op),
    .in_red      (in_red),
    .in_vd       (in_vd),
    .in_vs1      (in_vs1),
    .in_vs2      (in_vs2),
    .in_src1_sel (in_src1_sel),
    .in_rs1      (in_rs1),
    .in_imm      (in_imm),
    .in_mask_en  (in_mask_en),
    .in_regwen   (in_regwen),
    .vl          (vl),
    .bank_a      (bank_a),
    .bank_b      (bank_b),
    .lane0_v0    (v0_words[0]),
    .ex_vd       (ex_q_payload.vd),
    .wb_vd       (wb_q_payload.vd),
    .ex_busy     (ex_q_valid && ex_q_payload.regwen),
    .wb_busy     (out_valid && out_regwen),
    .ex_valid    (ex_valid),
    .ex_ready    (ex_ready),
    .ex_payload  (ex_payload)
);

stage_reg #(.payload_t(vex_pkg::ex_payload_t)) u_ex_stage (
    .CLK          (CLK),
    .arst_n       (arst_n),
    .up_valid     (ex_valid),
    .up_ready     (ex_ready),
    .up_payload   (ex_payload),
    .down_valid   (ex_q_valid),
    .down_ready   (ex_q_ready),
    .down_payload (ex_q_payload)
);

// reduction runs over the vs2 elements
reduction_unit u_red (
    .op        (ex_q_payload.op),
    .elems     (ex_q_payload.a),
    .lane_mask (ex_q_payload.lane_mask),
    .seed      (ex_q_payload.seed[0]),
    .res       (red_res)
);

result_select u_sel (
    .ex_payload (ex_q_payload),
    .lane_res   (lane_res),
    .red_res    (red_res),
    .wb_payload (wb_payload)
);

stage_reg #(.payload_t(vex_pkg::wb_payload_t)) u_wb_stage (
    .CLK          (CLK),
    .arst_n       (arst_n),
    .up_valid     (ex_q_valid),
    .up_ready     (ex_q_ready),
    .up_payload   (wb_payload),
    .down_valid   (out_valid),
    .down_ready   (out_ready),
    .down_payload (wb_q_payload)
);

assign out_vd        = wb_q_payload.vd;
assign out_regwen    = wb_q_payload.regwen;
assign out_lane_mask = wb_q_payload.lane_mask;
assign out_data      = wb_q_payload.result;

endmodule

/* hw/vlane_alu.sv */
`timescale 1ns/1ps

module vlane_alu (
    input  vex_pkg::valu_op_t op,
    input  vex_pkg::word_t    a,
    input  vex_pkg::word_t    b,
    output vex_pkg::word_t    res
);

logic a_lt_b_s;
logic a_lt_b_u;

assign a_lt_b_s = $signed(a) < $signed(b);
assign a_lt_b_u = a < b;

always_comb begin
    case (op)
        vex_pkg::valu_add:  res = a + b;
        // a is vs2, so this is vs2 - b
        vex_pkg::valu_sub:  res = a - b;
        vex_pkg::valu_and:  res = a & b;
        vex_pkg::valu_or:   res = a | b;
        vex_pkg::valu_xor:  res = a ^ b;
        vex_pkg::valu_min:  res = a_lt_b_s ? a : b;
        vex_pkg::valu_max:  res = a_lt_b_s ? b : a;
        vex_pkg::valu_minu: res = a_lt_b_u ? a : b;
        vex_pkg::valu_maxu: res = a_lt_b_u ? b : a;
        default:            res = '0;
    endcase
end

endmodule

/* hw/vreg_bank.sv */
`timescale 1ns/1ps

module vreg_bank (
    input  logic                              CLK,
    input  logic                              arst_n,
    input  vex_pkg::vreg_idx_t                rd_idx_a,
    input  vex_pkg::vreg_idx_t                rd_idx_b,
    input  vex_pkg::vreg_idx_t                wr_idx,
    input  logic [vex_pkg::word_bytes-1:0]    wr_byte_en,
    input  vex_pkg::word_t                    wr_data,
    output vex_pkg::word_t                    rd_a,
    output vex_pkg::word_t                    rd_b,
    output vex_pkg::word_t                    rd_v0
);

// this lane's element of every vector register
vex_pkg::word_t regs [vex_pkg::num_vregs];

always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
        for (int i = 0; i < vex_pkg::num_vregs; i++) begin
            regs[i] <= '0;
        end
    end else begin
        // byte lanes written independently
        for (int b = 0; b < vex_pkg::word_bytes; b++) begin
            if (wr_byte_en[b]) begin
                regs[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
            end
        end
    end
end

// combinational reads so a write shows up the next cycle
assign rd_a  = regs[rd_idx_a];
assign rd_b  = regs[rd_idx_b];

// mask register is always v0
assign rd_v0 = regs[0];

endmodule

/* sim/tb_vex.sv */
`timescale 1ns/1ps

module tb_vex;

localparam logic [31:0] rng_seed       = 32'h0bd6_57e9;
localparam int          accept_timeout = 200;
localparam int          drain_timeout  = 500;
localparam int          num_random     = 400;

// one outstanding uop as the model predicts it
typedef struct packed {
    vex_pkg::vreg_idx_t   vd;
    logic                 regwen;
    vex_pkg::lane_mask_t  mask;
    vex_pkg::lane_mask_t  cmp;
    vex_pkg::lane_words_t data;
} exp_t;

logic                 CLK;
logic                 arst_n;
logic                 in_valid;
logic                 in_ready;
vex_pkg::valu_op_t    in_op;
logic                 in_red;
vex_pkg::vreg_idx_t   in_vd;
vex_pkg::vreg_idx_t   in_vs1;
vex_pkg::vreg_idx_t   in_vs2;
vex_pkg::vsrc1_sel_t  in_src1_sel;
vex_pkg::word_t       in_rs1;
logic [4:0]           in_imm;
logic                 in_mask_en;
logic                 in_regwen;
vex_pkg::word_t       vl;
logic                 out_valid;
logic                 out_ready = 1'b0;
vex_pkg::vreg_idx_t   out_vd;
logic                 out_regwen;
vex_pkg::lane_mask_t  out_lane_mask;
vex_pkg::lane_words_t out_data;

logic [31:0]          stim_state  = rng_seed;
logic [31:0]          ready_state = ~rng_seed;
vex_pkg::word_t       mirror [vex_pkg::num_vregs][vex_pkg::num_lanes];
exp_t                 exp_q [$];
int                   exp_count = 0;
vex_pkg::vreg_idx_t   exp_vd;
logic                 exp_regwen;
vex_pkg::lane_mask_t  exp_mask;
vex_pkg::lane_words_t exp_data;
vex_pkg::lane_words_t exp_bits;
int                   err_reset   = 0;
int                   err_output  = 0;
int                   err_flow    = 0;
int                   err_timeout = 0;
logic                 timed_out   = 1'b0;

vex_top i_dut (
    .CLK           (CLK),
    .arst_n        (arst_n),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .in_op         (in_op),
    .in_red        (in_red),
    .in_vd         (in_vd),
    .in_vs1        (in_vs1),
    .in_vs2        (in_vs2),
    .in_src1_sel   (in_src1_sel),
    .in_rs1        (in_rs1),
    .in_imm        (in_imm),
    .in_mask_en    (in_mask_en),
    .in_regwen     (in_regwen),
    .vl            (vl),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .out_vd        (out_vd),
    .out_regwen    (out_regwen),
    .out_lane_mask (out_lane_mask),
    .out_data      (out_data)
);

function automatic logic [31:0] xorshift32(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic int unsigned pick(int unsigned n);
    stim_state = xorshift32(stim_state);
    return stim_state % n;
endfunction

function automatic vex_pkg::word_t alu_ref(vex_pkg::valu_op_t op, vex_pkg::word_t x,
                                           vex_pkg::word_t y);
    vex_pkg::word_t xs;
    vex_pkg::word_t ys;
    // offset binary turns signed order into unsigned order
    xs = x ^ 32'h8000_0000;
    ys = y ^ 32'h8000_0000;
    case (op)
        vex_pkg::valu_add:  return x + y;
        vex_pkg::valu_sub:  return x - y;
        vex_pkg::valu_and:  return x & y;
        vex_pkg::valu_or:   return x | y;
        vex_pkg::valu_xor:  return x ^ y;
        vex_pkg::valu_min:  return (xs < ys) ? x : y;
        vex_pkg::valu_max:  return (xs > ys) ? x : y;
        vex_pkg::valu_minu: return (x < y) ? x : y;
        vex_pkg::valu_maxu: return (x > y) ? x : y;
        default:            return '0;
    endcase
endfunction

// program-order value from the committed mirror with pending writes applied oldest first
function automatic vex_pkg::word_t arch_elem(vex_pkg::vreg_idx_t r, int k);
    vex_pkg::word_t v;
    v = mirror[r][k];
    foreach (exp_q[i]) begin
        if (exp_q[i].regwen && (exp_q[i].vd == r) && exp_q[i].mask[k]) begin
            v = exp_q[i].data[k];
        end
    end
    return v;
endfunction

function automatic vex_pkg::lane_words_t lane_bits(vex_pkg::lane_mask_t m);
    vex_pkg::lane_words_t w;
    for (int k = 0; k < vex_pkg::num_lanes; k++) begin
        w[k] = {vex_pkg::word_w{m[k]}};
    end
    return w;
endfunction

// expected result of the uop now on the input port
function automatic exp_t predict_uop();
    exp_t                e;
    vex_pkg::word_t      v0w;
    vex_pkg::word_t      b;
    vex_pkg::word_t      acc;
    vex_pkg::lane_mask_t active;
    v0w = arch_elem('0, 0);
    for (int k = 0; k < vex_pkg::num_lanes; k++) begin
        active[k] = (vl > 32'(k)) && (!in_mask_en || v0w[k]);
    end
    e.vd     = in_vd;
    e.regwen = in_regwen;
    e.data   = '0;
    if (in_red) begin
        // skipping inactive lanes equals padding them with the identity
        acc = arch_elem(in_vs1, 0);
        for (int k = 0; k < vex_pkg::num_lanes; k++) begin
            if (active[k]) begin
                acc = alu_ref(in_op, acc, arch_elem(in_vs2, k));
            end
        end
        e.data[0] = acc;
        e.mask    = 4'b0001;
        e.cmp     = 4'b0001;
    end else begin
        for (int k = 0; k < vex_pkg::num_lanes; k++) begin
            case (in_src1_sel)
                vex_pkg::src1_scalar: b = in_rs1;
                vex_pkg::src1_imm:    b = vex_pkg::word_t'($signed(in_imm));
                default:              b = arch_elem(in_vs1, k);
            endcase
            e.data[k] = alu_ref(in_op, arch_elem(in_vs2, k), b);
        end
        e.mask = active;
        e.cmp  = 4'b1111;
    end
    return e;
endfunction

task automatic send_uop(vex_pkg::valu_op_t op, logic red, vex_pkg::vreg_idx_t vd,
                        vex_pkg::vreg_idx_t vs1, vex_pkg::vreg_idx_t vs2,
                        vex_pkg::vsrc1_sel_t sel, vex_pkg::word_t rs1, logic [4:0] imm,
                        logic mask_en, logic regwen, vex_pkg::word_t vl_v);
    int   waited;
    logic accepted;
    in_op       <= op;
    in_red      <= red;
    in_vd       <= vd;
    in_vs1      <= vs1;
    in_vs2      <= vs2;
    in_src1_sel <= sel;
    in_rs1      <= rs1;
    in_imm      <= imm;
    in_mask_en  <= mask_en;
    in_regwen   <= regwen;
    vl          <= vl_v;
    in_valid    <= 1'b1;
    waited   = 0;
    accepted = 1'b0;
    while (!accepted && waited < accept_timeout) begin
        @(posedge CLK);
        accepted = in_ready;
        waited++;
    end
    in_valid <= 1'b0;
    if (!accepted) begin
        timed_out = 1'b1;
        err_timeout++;
        $display("input port never accepted a uop within %0d cycles", accept_timeout);
    end
endtask

initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
end

// random back-pressure on the output port
always @(posedge CLK) begin
    ready_state = xorshift32(ready_state);
    out_ready <= (ready_state[2:0] > 3'd2);
end

// reference model predicts at acceptance and commits at output transfer
always @(posedge CLK) begin
    exp_t nxt;
    logic took;
    if (!arst_n) begin
        for (int r = 0; r < vex_pkg::num_vregs; r++) begin
            for (int k = 0; k < vex_pkg::num_lanes; k++) begin
                mirror[r][k] = '0;
            end
        end
        exp_q.delete();
    end else begin
        took = in_valid && in_ready;
        if (took) begin
            nxt = predict_uop();
        end
        if (out_valid && out_ready && (exp_q.size() != 0)) begin
            for (int k = 0; k < vex_pkg::num_lanes; k++) begin
                if (exp_q[0].regwen && exp_q[0].mask[k]) begin
                    mirror[exp_q[0].vd][k] = exp_q[0].data[k];
                end
            end
            void'(exp_q.pop_front());
        end
        if (took) begin
            exp_q.push_back(nxt);
        end
    end
    exp_count <= exp_q.size();
    if (exp_q.size() != 0) begin
        exp_vd     <= exp_q[0].vd;
        exp_regwen <= exp_q[0].regwen;
        exp_mask   <= exp_q[0].mask;
        exp_data   <= exp_q[0].data;
        exp_bits   <= lane_bits(exp_q[0].cmp);
    end
end

a_reset_state: assert property (@(posedge CLK) $rose(arst_n) |-> (in_ready && !out_valid))
    else begin
        err_reset++;
        $display("Fail in_ready/out_valid after reset: got %h/%h expected 1/0",
                 $sampled(in_ready), $sampled(out_valid));
    end

a_no_extra: assert property (@(posedge CLK) disable iff (!arst_n)
    out_valid |-> (exp_count != 0))
    else begin
        err_flow++;
        $display("result on the output port with no accepted uop outstanding");
    end

a_out_vd: assert property (@(posedge CLK) disable iff (!arst_n)
    (out_valid && exp_count != 0) |-> (out_vd == exp_vd))
    else begin
        err_output++;
        $display("Fail out_vd: got %h expected %h", $sampled(out_vd), $sampled(exp_vd));
    end

a_out_regwen: assert property (@(posedge CLK) disable iff (!arst_n)
    (out_valid && exp_count != 0) |-> (out_regwen == exp_regwen))
    else begin
        err_output++;
        $display("Fail out_regwen: got %h expected %h",
                 $sampled(out_regwen), $sampled(exp_regwen));
    end

a_out_mask: assert property (@(posedge CLK) disable iff (!arst_n)
    (out_valid && exp_count != 0) |-> (out_lane_mask == exp_mask))
    else begin
        err_output++;
        $display("Fail out_lane_mask: got %h expected %h",
                 $sampled(out_lane_mask), $sampled(exp_mask));
    end

a_out_data: assert property (@(posedge CLK) disable iff (!arst_n)
    (out_valid && exp_count != 0) |-> (((out_data ^ exp_data) & exp_bits) == '0))
    else begin
        err_output++;
        $display("Fail out_data: got %h expected %h", $sampled(out_data), $sampled(exp_data));
    end

a_out_hold: assert property (@(posedge CLK) disable iff (!arst_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_vd) && $stable(out_regwen) &&
                                   $stable(out_lane_mask) && $stable(out_data)))
    else begin
        err_flow++;
        $display("output port fields changed or dropped while stalled");
    end

initial begin
    int                  i;
    int unsigned         op_i;
    logic                red;
    vex_pkg::vreg_idx_t  vd;
    vex_pkg::vreg_idx_t  vs2;
    vex_pkg::vreg_idx_t  last_vd;
    vex_pkg::word_t      vl_v;
    int                  waited;
    in_valid    = 1'b0;
    in_op       = vex_pkg::valu_add;
    in_red      = 1'b0;
    in_vd       = '0;
    in_vs1      = '0;
    in_vs2      = '0;
    in_src1_sel = vex_pkg::src1_vec;
    in_rs1      = '0;
    in_imm      = '0;
    in_mask_en  = 1'b0;
    in_regwen   = 1'b0;
    vl          = '0;
    arst_n      = 1'b0;
    repeat (16) @(posedge CLK);
    arst_n <= 1'b1;
    @(posedge CLK);

    // seed every register with a scalar added onto zero
    i = 0;
    while (!timed_out && i < vex_pkg::num_vregs) begin
        send_uop(vex_pkg::valu_add, 1'b0, vex_pkg::vreg_idx_t'(i), '0,
                 vex_pkg::vreg_idx_t'(i), vex_pkg::src1_scalar, pick(32'hffff_ffff), '0,
                 1'b0, 1'b1, 32'd4);
        i++;
    end

    // random mix over a few registers with half of them chained on the last vd
    last_vd = '0;
    i = 0;
    while (!timed_out && i < num_random) begin
        red  = (pick(4) == 0);
        op_i = pick(9);
        if (red && op_i == 1) begin
            op_i = 0;
        end
        vd   = vex_pkg::vreg_idx_t'(pick(8));
        vs2  = (pick(2) == 0) ? last_vd : vex_pkg::vreg_idx_t'(pick(8));
        vl_v = (pick(8) == 0) ? stim_state : vex_pkg::word_t'(pick(6));
        send_uop(vex_pkg::valu_op_t'(4'(op_i)), red, vd, vex_pkg::vreg_idx_t'(pick(8)), vs2,
                 vex_pkg::vsrc1_sel_t'(2'(pick(3))), pick(32'hffff_ffff), 5'(pick(32)),
                 (pick(2) == 1), (pick(8) != 0), vl_v);
        last_vd = vd;
        if (pick(4) == 0) begin
            @(posedge CLK);
        end
        i++;
    end

    @(posedge CLK);
    waited = 0;
    while (!timed_out && exp_count != 0 && waited < drain_timeout) begin
        @(posedge CLK);
        waited++;
    end
    if (!timed_out && exp_count != 0) begin
        err_timeout++;
        $display("%0d accepted uops never came out on the output port", exp_count);
    end
    repeat (4) @(posedge CLK);

    $display("errors: reset %0d, output %0d, flow %0d, timeout %0d",
             err_reset, err_output, err_flow, err_timeout);
    if (err_reset + err_output + err_flow + err_timeout == 0) begin
        $display("Test passed");
    end else begin
        $display("Test failed");
    end
    $finish;
end

endmodule

/* vex.f */
hw/vex_pkg.sv
hw/vreg_bank.sv
hw/operand_fetch.sv
hw/stage_reg.sv
hw/vlane_alu.sv
hw/reduction_unit.sv
hw/result_select.sv
hw/vex_top.sv
sim/tb_vex.sv
